// File: source/pyr_pkg.sv
// Mode encodings and widths for all pyramid stages; mode inputs must use exactly these codes
package pyr_pkg;

   ////////////////////
   // Mode field
   ////////////////////

   // One field per layer on the top-level mode bus
   localparam int PYR_MODE_W = 2;

   // 2x2 reduction modes
   // Mean of the block, truncated
   localparam logic [PYR_MODE_W-1:0] PYR_MODE_AVG = 2'd0;
   // Top-left pixel kept
   localparam logic [PYR_MODE_W-1:0] PYR_MODE_DEC = 2'd1;
   // Brightest pixel of the block
   localparam logic [PYR_MODE_W-1:0] PYR_MODE_MAX = 2'd2;
   // Darkest pixel of the block
   localparam logic [PYR_MODE_W-1:0] PYR_MODE_MIN = 2'd3;

   ////////////////////
   // Arithmetic growth
   ////////////////////

   // Sum of four pixels needs two more bits than one pixel.
   // A sum of two needs one, carried on the pair result.
   localparam int PYR_SUM_GROW = 2;

endpackage

// File: source/pyr_sync_track.sv
// Needs CAMSIZEX even and >= 4, lines of exactly CAMSIZEX pixels, a line valid gap between lines
`timescale 1ns/1ps

module pyr_sync_track #(
   parameter int CAMSIZEX = 1280
) (
   input  logic                            clk,
   input  logic                            i_rst,
   input  logic                            i_run,
   input  logic                            i_pixel_valid,
   input  logic                            i_line_valid,
   input  logic                            i_frame_valid,
   output logic                            o_col_odd,
   output logic                            o_row_odd,
   output logic [$clog2(CAMSIZEX/2)-1:0]   o_pair_idx,
   output logic                            o_line_valid,
   output logic                            o_frame_valid
);

   // Column count must be able to reach CAMSIZEX
   localparam int COL_W  = $clog2(CAMSIZEX + 1);
   localparam int PAIR_W = $clog2(CAMSIZEX / 2);

   logic              pix_take;
   logic [COL_W-1:0]  col_cnt;
   logic              row_odd;
   logic [PAIR_W-1:0] pair_idx;
   // Raw line valid, one cycle old
   logic              lv_q;
   // Masked line valid pipe
   logic              lv_d1;
   logic              lv_d2;
   // Frame valid pipe
   logic              fv_d1;
   logic              fv_d2;

   // Pixel only counts inside a line
   assign pix_take = i_pixel_valid & i_line_valid;

   ////////////////////
   // Position counters
   ////////////////////

   // Column count, cleared between lines
   always_ff @(posedge clk) begin
      if (i_rst || !i_run) begin
         col_cnt <= '0;
      end else if (!i_line_valid) begin
         col_cnt <= '0;
      end else if (pix_take) begin
         col_cnt <= col_cnt + 1'b1;
      end
   end

   // Row parity flips on each falling line valid
   // End of frame forces it back to even
   always_ff @(posedge clk) begin
      if (i_rst || !i_run) begin
         row_odd <= 1'b0;
      end else if (fv_d1 && !i_frame_valid) begin
         row_odd <= 1'b0;
      end else if (lv_q && !i_line_valid) begin
         row_odd <= ~row_odd;
      end
   end

   // Pair index latched on the odd column
   // so it lines up with the registered pair result
   always_ff @(posedge clk) begin
      if (i_rst || !i_run) begin
         pair_idx <= '0;
      end else if (pix_take && col_cnt[0]) begin
         pair_idx <= col_cnt[PAIR_W:1];
      end
   end

   ////////////////////
   // Sync delay
   ////////////////////

   // Two cycles to match the pixel path
   // Even rows produce no output line
   always_ff @(posedge clk) begin
      if (i_rst || !i_run) begin
         lv_q  <= 1'b0;
         lv_d1 <= 1'b0;
         lv_d2 <= 1'b0;
         fv_d1 <= 1'b0;
         fv_d2 <= 1'b0;
      end else begin
         lv_q  <= i_line_valid;
         lv_d1 <= i_line_valid & row_odd;
         lv_d2 <= lv_d1;
         fv_d1 <= i_frame_valid;
         fv_d2 <= fv_d1;
      end
   end

   assign o_col_odd     = col_cnt[0];
   assign o_row_odd     = row_odd;
   assign o_pair_idx    = pair_idx;
   assign o_line_valid  = lv_d2;
   assign o_frame_valid = fv_d2;

   // Upstream must never send more than one line width
   a_line_len : assert property (@(posedge clk) disable iff (i_rst || !i_run)
      pix_take |-> (col_cnt < COL_W'(CAMSIZEX)))
      else $error("pyr_sync_track: line longer than %0d pixels", CAMSIZEX);

endmodule

// File: source/pyr_pair_reduce.sv
// Only the result register of the current mode loads; mode must stay static within a frame
`timescale 1ns/1ps

module pyr_pair_reduce #(
   parameter int BPP = 8
) (
   input  logic                           clk,
   input  logic                           i_rst,
   input  logic                           i_run,
   input  logic [BPP-1:0]                 i_pixel,
   input  logic                           i_pixel_valid,
   input  logic                           i_line_valid,
   input  logic                           i_col_odd,
   input  logic [pyr_pkg::PYR_MODE_W-1:0] i_mode,
   output logic [BPP:0]                   o_pair,
   output logic [BPP-1:0]                 o_pair_max,
   output logic [BPP-1:0]                 o_pair_min,
   output logic [BPP-1:0]                 o_pair_first,
   output logic                           o_pair_valid
);

   logic           pix_take;
   logic           pair_done;
   // Even-column pixel waiting for its partner
   logic [BPP-1:0] even_q;
   logic [BPP:0]   sum_q;
   logic [BPP-1:0] max_q;
   logic [BPP-1:0] min_q;
   logic [BPP-1:0] first_q;
   logic           pair_valid_q;

   assign pix_take  = i_pixel_valid & i_line_valid;
   assign pair_done = pix_take & i_col_odd;

   // Hold left pixel of the pair
   always_ff @(posedge clk) begin
      if (pix_take && !i_col_odd) begin
         even_q <= i_pixel;
      end
   end

   ////////////////////
   // Pair results
   ////////////////////

   // Unused results keep their old value, less toggling
   always_ff @(posedge clk) begin
      if (pair_done) begin
         case (i_mode)
            pyr_pkg::PYR_MODE_AVG: sum_q   <= {1'b0, even_q} + {1'b0, i_pixel};
            pyr_pkg::PYR_MODE_DEC: first_q <= even_q;
            pyr_pkg::PYR_MODE_MAX: max_q   <= (even_q > i_pixel) ? even_q : i_pixel;
            default:               min_q   <= (even_q < i_pixel) ? even_q : i_pixel;
         endcase
      end
   end

   // Result valid one cycle after the odd column
   always_ff @(posedge clk) begin
      if (i_rst || !i_run) begin
         pair_valid_q <= 1'b0;
      end else begin
         pair_valid_q <= pair_done;
      end
   end

   assign o_pair       = sum_q;
   assign o_pair_max   = max_q;
   assign o_pair_min   = min_q;
   assign o_pair_first = first_q;
   assign o_pair_valid = pair_valid_q;

   // A pixel outside a line would shift column parity
   a_pv_in_line : assert property (@(posedge clk) disable iff (i_rst || !i_run)
      i_pixel_valid |-> i_line_valid)
      else $error("pyr_pair_reduce: pixel valid outside line valid");

endmodule

// File: source/pyr_vert_reduce.sv
// Line store holds one mode-selected result per pair; mode change mid-frame corrupts one line
`timescale 1ns/1ps

module pyr_vert_reduce #(
   parameter int CAMSIZEX = 1280,
   parameter int BPP      = 8
) (
   input  logic                            clk,
   input  logic                            i_rst,
   input  logic                            i_run,
   input  logic [BPP:0]                    i_pair,
   input  logic [BPP-1:0]                  i_pair_max,
   input  logic [BPP-1:0]                  i_pair_min,
   input  logic [BPP-1:0]                  i_pair_first,
   input  logic                            i_pair_valid,
   input  logic                            i_row_odd,
   input  logic [$clog2(CAMSIZEX/2)-1:0]   i_pair_idx,
   input  logic [pyr_pkg::PYR_MODE_W-1:0]  i_mode,
   output logic [BPP-1:0]                  o_pixel,
   output logic                            o_pixel_valid
);

   localparam int NPAIR  = CAMSIZEX / 2;
   localparam int QSUM_W = BPP + pyr_pkg::PYR_SUM_GROW;

   // One entry per pair of the even row
   logic [BPP:0]      line_mem [NPAIR];
   logic [BPP:0]      wr_word;
   logic [BPP:0]      rd_word;
   logic [BPP-1:0]    rd_pix;
   logic [QSUM_W-1:0] quad_sum;
   logic [BPP-1:0]    comb_pix;
   logic [BPP-1:0]    pixel_q;
   logic              pixel_valid_q;

   ////////////////////
   // Even row store
   ////////////////////

   // Pick the result the mode needs
   // Non-sum results zero-extended
   always_comb begin
      case (i_mode)
         pyr_pkg::PYR_MODE_AVG: wr_word = i_pair;
         pyr_pkg::PYR_MODE_DEC: wr_word = {1'b0, i_pair_first};
         pyr_pkg::PYR_MODE_MAX: wr_word = {1'b0, i_pair_max};
         default:               wr_word = {1'b0, i_pair_min};
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_run && i_pair_valid && !i_row_odd) begin
         line_mem[i_pair_idx] <= wr_word;
      end
   end

   ////////////////////
   // Odd row combine
   ////////////////////

   // Same column pair from the row above
   assign rd_word  = line_mem[i_pair_idx];
   assign rd_pix   = rd_word[BPP-1:0];
   assign quad_sum = QSUM_W'(rd_word) + QSUM_W'(i_pair);

   always_comb begin
      case (i_mode)
         // Divide by four, drop the fraction
         pyr_pkg::PYR_MODE_AVG: comb_pix = quad_sum[QSUM_W-1:pyr_pkg::PYR_SUM_GROW];
         // Top-left lives in the upper row
         pyr_pkg::PYR_MODE_DEC: comb_pix = rd_pix;
         pyr_pkg::PYR_MODE_MAX: comb_pix = (rd_pix > i_pair_max) ? rd_pix : i_pair_max;
         default:               comb_pix = (rd_pix < i_pair_min) ? rd_pix : i_pair_min;
      endcase
   end

   // Output register, second cycle of layer latency
   always_ff @(posedge clk) begin
      if (i_pair_valid && i_row_odd) begin
         pixel_q <= comb_pix;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst || !i_run) begin
         pixel_valid_q <= 1'b0;
      end else begin
         pixel_valid_q <= i_pair_valid & i_row_odd;
      end
   end

   assign o_pixel       = pixel_q;
   assign o_pixel_valid = pixel_valid_q;

   // Index comes from the tracker, must be settled with the pair
   a_pair_idx_known : assert property (@(posedge clk) disable iff (i_rst || !i_run)
      i_pair_valid |-> !$isunknown(i_pair_idx))
      else $error("pyr_vert_reduce: pair valid with unknown pair index");

endmodule

// File: source/pyr_layer.sv
// One halving stage, 2 cycles latency; input line width must equal CAMSIZEX, frames even height
`timescale 1ns/1ps

module pyr_layer #(
   parameter int CAMSIZEX = 1280,
   parameter int BPP      = 8
) (
   input  logic                           clk,
   input  logic                           i_rst,
   input  logic                           i_run,
   input  logic [pyr_pkg::PYR_MODE_W-1:0] i_mode,
   input  logic [BPP-1:0]                 i_pixel,
   input  logic                           i_pixel_valid,
   input  logic                           i_line_valid,
   input  logic                           i_frame_valid,
   output logic [BPP-1:0]                 o_pixel,
   output logic                           o_pixel_valid,
   output logic                           o_line_valid,
   output logic                           o_frame_valid
);

   localparam int PAIR_W = $clog2(CAMSIZEX / 2);

   // Position of the current pixel
   logic              col_odd;
   logic              row_odd;
   logic [PAIR_W-1:0] pair_idx;
   // Horizontal pair results
   logic [BPP:0]      pair;
   logic [BPP-1:0]    pair_max;
   logic [BPP-1:0]    pair_min;
   logic [BPP-1:0]    pair_first;
   logic              pair_valid;

   ////////////////////
   // Position and sync
   ////////////////////

   pyr_sync_track #(
      .CAMSIZEX (CAMSIZEX)
   ) u_sync_track (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_run         (i_run),
      .i_pixel_valid (i_pixel_valid),
      .i_line_valid  (i_line_valid),
      .i_frame_valid (i_frame_valid),
      .o_col_odd     (col_odd),
      .o_row_odd     (row_odd),
      .o_pair_idx    (pair_idx),
      .o_line_valid  (o_line_valid),
      .o_frame_valid (o_frame_valid)
   );

   // Horizontal step
   pyr_pair_reduce #(
      .BPP (BPP)
   ) u_pair_reduce (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_run         (i_run),
      .i_pixel       (i_pixel),
      .i_pixel_valid (i_pixel_valid),
      .i_line_valid  (i_line_valid),
      .i_col_odd     (col_odd),
      .i_mode        (i_mode),
      .o_pair        (pair),
      .o_pair_max    (pair_max),
      .o_pair_min    (pair_min),
      .o_pair_first  (pair_first),
      .o_pair_valid  (pair_valid)
   );

   // Vertical step, drives the stage pixel
   pyr_vert_reduce #(
      .CAMSIZEX (CAMSIZEX),
      .BPP      (BPP)
   ) u_vert_reduce (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_run         (i_run),
      .i_pair        (pair),
      .i_pair_max    (pair_max),
      .i_pair_min    (pair_min),
      .i_pair_first  (pair_first),
      .i_pair_valid  (pair_valid),
      .i_row_odd     (row_odd),
      .i_pair_idx    (pair_idx),
      .i_mode        (i_mode),
      .o_pixel       (o_pixel),
      .o_pixel_valid (o_pixel_valid)
   );

endmodule

// File: source/pyramid_gen.sv
// Layer k output is 2(k+1) cycles late; CAMSIZEX >> (NUMLAYERS-1) must stay even and >= 4
`timescale 1ns/1ps

module pyramid_gen #(
   parameter int NUMLAYERS = 4,
   parameter int CAMSIZEX  = 1280,
   parameter int BPP       = 8
) (
   input  logic                     clk,
   input  logic                     i_rst,
   input  logic [BPP-1:0]           i_pixel,
   input  logic                     i_pixel_valid,
   input  logic                     i_line_valid,
   input  logic                     i_frame_valid,
   // Two mode bits per layer, layer 0 in the low field
   input  logic [2*NUMLAYERS-1:0]   i_mode,
   input  logic [NUMLAYERS-1:0]     i_pyr_out_en,
   output logic [NUMLAYERS*BPP-1:0] o_pixel,
   output logic [NUMLAYERS-1:0]     o_pixel_valid,
   output logic [NUMLAYERS-1:0]     o_line_valid,
   output logic [NUMLAYERS-1:0]     o_frame_valid
);

   // Stream between stages, index 0 is the camera
   logic [BPP-1:0]       chain_pixel [NUMLAYERS+1];
   logic [NUMLAYERS:0]   chain_pixel_valid;
   logic [NUMLAYERS:0]   chain_line_valid;
   logic [NUMLAYERS:0]   chain_frame_valid;
   // Per-stage clock enable
   logic [NUMLAYERS-1:0] layer_run;

   assign chain_pixel[0]       = i_pixel;
   assign chain_pixel_valid[0] = i_pixel_valid;
   assign chain_line_valid[0]  = i_line_valid;
   assign chain_frame_valid[0] = i_frame_valid;

   ////////////////////
   // Layer chain
   ////////////////////

   for (genvar k = 0; k < NUMLAYERS; k++) begin : g_layer

      // Stage must run if it or any deeper layer is wanted
      assign layer_run[k] = |i_pyr_out_en[NUMLAYERS-1:k];

      // Each stage sees half the width of the one before
      pyr_layer #(
         .CAMSIZEX (CAMSIZEX >> k),
         .BPP      (BPP)
      ) u_layer (
         .clk           (clk),
         .i_rst         (i_rst),
         .i_run         (layer_run[k]),
         .i_mode        (i_mode[2*k +: 2]),
         .i_pixel       (chain_pixel[k]),
         .i_pixel_valid (chain_pixel_valid[k]),
         .i_line_valid  (chain_line_valid[k]),
         .i_frame_valid (chain_frame_valid[k]),
         .o_pixel       (chain_pixel[k+1]),
         .o_pixel_valid (chain_pixel_valid[k+1]),
         .o_line_valid  (chain_line_valid[k+1]),
         .o_frame_valid (chain_frame_valid[k+1])
      );

      // Disabled layer reads as zero
      // chain itself stays ungated for deeper layers
      assign o_pixel[k*BPP +: BPP] = i_pyr_out_en[k] ? chain_pixel[k+1] : '0;
      assign o_pixel_valid[k]      = i_pyr_out_en[k] & chain_pixel_valid[k+1];
      assign o_line_valid[k]       = i_pyr_out_en[k] & chain_line_valid[k+1];
      assign o_frame_valid[k]      = i_pyr_out_en[k] & chain_frame_valid[k+1];

   end

endmodule

// File: verif/pyramid_gen_tb.sv
// Fixed at 2 layers on a 16 pixel line, frames of 4 or 8 lines; outputs sampled on the falling edge
`timescale 1ns/1ps

module pyramid_gen_tb;

   localparam int NUMLAYERS = 2;
   localparam int CAMSIZEX  = 16;
   localparam int BPP       = 8;
   localparam int NROWS     = 8;
   localparam int DRAIN_MAX = 300;

   // One table row holds modes, enables, pixel source, frame height and gaps
   typedef struct packed {
      logic [1:0] mode0;
      logic [1:0] mode1;
      logic [1:0] en;
      logic       lfsr_src;
      logic [3:0] height;
      logic       gaps;
   } row_t;

   logic                     clk;
   logic                     i_rst;
   logic [BPP-1:0]           i_pixel;
   logic                     i_pixel_valid;
   logic                     i_line_valid;
   logic                     i_frame_valid;
   logic [2*NUMLAYERS-1:0]   i_mode;
   logic [NUMLAYERS-1:0]     i_pyr_out_en;
   logic [NUMLAYERS*BPP-1:0] o_pixel;
   logic [NUMLAYERS-1:0]     o_pixel_valid;
   logic [NUMLAYERS-1:0]     o_line_valid;
   logic [NUMLAYERS-1:0]     o_frame_valid;

   row_t        tbl [NROWS];
   logic [31:0] lfsr_state;
   // Input image and the two expected pyramid levels
   logic [BPP-1:0] img0 [8][CAMSIZEX];
   logic [BPP-1:0] img1 [4][CAMSIZEX/2];
   logic [BPP-1:0] img2 [2][CAMSIZEX/4];
   logic [BPP-1:0] exp0_q [$];
   logic [BPP-1:0] exp1_q [$];
   logic [BPP-1:0] got0_q [$];
   logic [BPP-1:0] got1_q [$];
   logic [1:0]     cur_en;
   logic [1:0]     lv_prev;
   logic [1:0]     fv_prev;
   int             lv_rise [NUMLAYERS];
   int             fv_rise [NUMLAYERS];
   // Pixels seen inside the current output line
   int             line_pix [NUMLAYERS];
   int             mismatch_cnt;
   int             fail_cnt;

   pyramid_gen #(
      .NUMLAYERS (NUMLAYERS),
      .CAMSIZEX  (CAMSIZEX),
      .BPP       (BPP)
   ) u_pyramid_gen (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_pixel       (i_pixel),
      .i_pixel_valid (i_pixel_valid),
      .i_line_valid  (i_line_valid),
      .i_frame_valid (i_frame_valid),
      .i_mode        (i_mode),
      .i_pyr_out_en  (i_pyr_out_en),
      .o_pixel       (o_pixel),
      .o_pixel_valid (o_pixel_valid),
      .o_line_valid  (o_line_valid),
      .o_frame_valid (o_frame_valid)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////
   // Helpers
   ////////////////////

   task automatic check_value(input logic [31:0] got, input logic [31:0] expv, input string what);
      if (got !== expv) begin
         mismatch_cnt++;
         $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, expv);
      end
   endtask

   // Galois form with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // One LFSR step per bit taken
   function automatic int take_bits(input int n);
      int val;
      val = 0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val = (val << 1) | int'(lfsr_state[0]);
      end
      return val;
   endfunction

   function automatic row_t make_row(input logic [1:0] m0, input logic [1:0] m1,
                                     input logic [1:0] en, input logic lfsr_src,
                                     input logic [3:0] h, input logic gaps);
      return {m0, m1, en, lfsr_src, h, gaps};
   endfunction

   // 2x2 block rule with a top-left, b top-right and c and d in the row below
   function automatic logic [BPP-1:0] reduce_block(input logic [1:0] mode,
         input logic [BPP-1:0] a, input logic [BPP-1:0] b,
         input logic [BPP-1:0] c, input logic [BPP-1:0] d);
      logic [BPP+1:0] sum;
      logic [BPP-1:0] pick;
      pick = a;
      case (mode)
         pyr_pkg::PYR_MODE_AVG: begin
            sum  = a + b + c + d;
            pick = sum[BPP+1:2];
         end
         pyr_pkg::PYR_MODE_DEC: pick = a;
         pyr_pkg::PYR_MODE_MAX: begin
            if (b > pick) pick = b;
            if (c > pick) pick = c;
            if (d > pick) pick = d;
         end
         default: begin
            if (b < pick) pick = b;
            if (c < pick) pick = c;
            if (d < pick) pick = d;
         end
      endcase
      return pick;
   endfunction

   ////////////////////
   // Stimulus
   ////////////////////

   // Inputs change 1 ns after the edge
   task automatic drive_cycle(input logic pv, input logic lv, input logic fv,
                              input logic [BPP-1:0] pix);
      @(posedge clk);
      #1;
      i_pixel_valid = pv;
      i_line_valid  = lv;
      i_frame_valid = fv;
      i_pixel       = pix;
   endtask

   task automatic fill_image(input row_t r);
      for (int y = 0; y < int'(r.height); y++) begin
         for (int x = 0; x < CAMSIZEX; x++) begin
            if (r.lfsr_src) begin
               img0[y][x] = BPP'(take_bits(BPP));
            end else begin
               img0[y][x] = BPP'((y * CAMSIZEX + x) * 3);
            end
         end
      end
   endtask

   // Level 1 from the input and level 2 from level 1
   task automatic build_model(input row_t r);
      exp0_q.delete();
      exp1_q.delete();
      for (int y = 0; y < int'(r.height) / 2; y++) begin
         for (int x = 0; x < CAMSIZEX / 2; x++) begin
            img1[y][x] = reduce_block(r.mode0, img0[2*y][2*x], img0[2*y][2*x+1],
                                      img0[2*y+1][2*x], img0[2*y+1][2*x+1]);
            if (r.en[0]) exp0_q.push_back(img1[y][x]);
         end
      end
      for (int y = 0; y < int'(r.height) / 4; y++) begin
         for (int x = 0; x < CAMSIZEX / 4; x++) begin
            img2[y][x] = reduce_block(r.mode1, img1[2*y][2*x], img1[2*y][2*x+1],
                                      img1[2*y+1][2*x], img1[2*y+1][2*x+1]);
            if (r.en[1]) exp1_q.push_back(img2[y][x]);
         end
      end
   endtask

   task automatic send_frame(input row_t r);
      int gap;
      repeat (2) drive_cycle(1'b0, 1'b0, 1'b1, '0);
      for (int y = 0; y < int'(r.height); y++) begin
         for (int x = 0; x < CAMSIZEX; x++) begin
            // Zero to three idle cycles inside the line
            if (r.gaps) begin
               gap = take_bits(2);
               repeat (gap) drive_cycle(1'b0, 1'b1, 1'b1, '0);
            end
            drive_cycle(1'b1, 1'b1, 1'b1, img0[y][x]);
         end
         // Gap between lines
         repeat (3) drive_cycle(1'b0, 1'b0, 1'b1, '0);
      end
      drive_cycle(1'b0, 1'b0, 1'b0, '0);
   endtask

   // Until both layers delivered and the syncs went low
   task automatic wait_drain(input int idx);
      int cnt;
      cnt = 0;
      while (!(got0_q.size() >= exp0_q.size() && got1_q.size() >= exp1_q.size() &&
               o_line_valid == '0 && o_frame_valid == '0) && cnt < DRAIN_MAX) begin
         @(posedge clk);
         #1;
         cnt++;
      end
      if (cnt >= DRAIN_MAX) begin
         fail_cnt++;
         $display("timeout: layer outputs did not finish for table row %0d", idx);
      end
   endtask

   task automatic compare_frame(input int idx, input row_t r);
      int n;
      check_value(got0_q.size(), exp0_q.size(), $sformatf("row %0d layer 0 pixel count", idx));
      check_value(got1_q.size(), exp1_q.size(), $sformatf("row %0d layer 1 pixel count", idx));
      n = (got0_q.size() < exp0_q.size()) ? got0_q.size() : exp0_q.size();
      for (int i = 0; i < n; i++) begin
         check_value(got0_q[i], exp0_q[i], $sformatf("row %0d layer 0 pixel %0d", idx, i));
      end
      n = (got1_q.size() < exp1_q.size()) ? got1_q.size() : exp1_q.size();
      for (int i = 0; i < n; i++) begin
         check_value(got1_q[i], exp1_q[i], $sformatf("row %0d layer 1 pixel %0d", idx, i));
      end
      // Line pulses halve per layer and each frame pulses once
      for (int k = 0; k < NUMLAYERS; k++) begin
         check_value(lv_rise[k], r.en[k] ? (int'(r.height) >> (k + 1)) : 0,
                     $sformatf("row %0d layer %0d line valid pulses", idx, k));
         check_value(fv_rise[k], r.en[k] ? 1 : 0,
                     $sformatf("row %0d layer %0d frame valid pulses", idx, k));
      end
   endtask

   ////////////////////
   // Monitor
   ////////////////////

   always @(negedge clk) begin
      if (!i_rst) begin
         if (o_pixel_valid[0]) got0_q.push_back(o_pixel[BPP-1:0]);
         if (o_pixel_valid[1]) got1_q.push_back(o_pixel[2*BPP-1:BPP]);
         for (int k = 0; k < NUMLAYERS; k++) begin
            if (o_line_valid[k] && !lv_prev[k]) lv_rise[k]++;
            if (o_frame_valid[k] && !fv_prev[k]) fv_rise[k]++;
            // Only pixels framed by the output line valid count
            if (o_pixel_valid[k] && o_line_valid[k]) line_pix[k]++;
            // Every closed output line carries the halved width
            if (!o_line_valid[k] && lv_prev[k]) begin
               check_value(line_pix[k], CAMSIZEX >> (k + 1),
                           $sformatf("layer %0d pixels in one output line", k));
               line_pix[k] = 0;
            end
            // Disabled layer must read all zero
            if (!cur_en[k]) begin
               check_value({o_pixel[k*BPP +: BPP], o_pixel_valid[k], o_line_valid[k],
                            o_frame_valid[k]}, '0, $sformatf("layer %0d disabled output", k));
            end
         end
         lv_prev = o_line_valid;
         fv_prev = o_frame_valid;
      end
   end

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      i_rst         = 1'b1;
      i_pixel       = '0;
      i_pixel_valid = 1'b0;
      i_line_valid  = 1'b0;
      i_frame_valid = 1'b0;
      i_mode        = '0;
      i_pyr_out_en  = 2'b11;
      cur_en        = 2'b11;
      lv_prev       = '0;
      fv_prev       = '0;
      mismatch_cnt  = 0;
      fail_cnt      = 0;
      lfsr_state    = 32'h7c5a;
      for (int k = 0; k < NUMLAYERS; k++) begin
         line_pix[k] = 0;
      end

      // mode0, mode1, enables, lfsr source, height, gaps
      tbl[0] = make_row(pyr_pkg::PYR_MODE_AVG, pyr_pkg::PYR_MODE_AVG, 2'b11, 1'b0, 4'd4, 1'b0);
      tbl[1] = make_row(pyr_pkg::PYR_MODE_DEC, pyr_pkg::PYR_MODE_MAX, 2'b11, 1'b1, 4'd8, 1'b0);
      tbl[2] = make_row(pyr_pkg::PYR_MODE_MIN, pyr_pkg::PYR_MODE_DEC, 2'b11, 1'b1, 4'd4, 1'b1);
      tbl[3] = make_row(pyr_pkg::PYR_MODE_MAX, pyr_pkg::PYR_MODE_MIN, 2'b11, 1'b1, 4'd8, 1'b1);
      tbl[4] = make_row(pyr_pkg::PYR_MODE_AVG, pyr_pkg::PYR_MODE_AVG, 2'b11, 1'b0, 4'd8, 1'b1);
      // Layer 0 hidden but still feeding layer 1
      tbl[5] = make_row(pyr_pkg::PYR_MODE_MAX, pyr_pkg::PYR_MODE_AVG, 2'b10, 1'b1, 4'd8, 1'b0);
      tbl[6] = make_row(pyr_pkg::PYR_MODE_AVG, pyr_pkg::PYR_MODE_AVG, 2'b00, 1'b0, 4'd4, 1'b0);
      tbl[7] = make_row(pyr_pkg::PYR_MODE_MIN, pyr_pkg::PYR_MODE_MIN, 2'b01, 1'b1, 4'd4, 1'b1);

      repeat (3) @(posedge clk);
      #1;
      i_rst = 1'b0;

      for (int i = 0; i < NROWS; i++) begin
         // Static controls change only between frames
         i_mode       = {tbl[i].mode1, tbl[i].mode0};
         i_pyr_out_en = tbl[i].en;
         cur_en       = tbl[i].en;
         repeat (4) drive_cycle(1'b0, 1'b0, 1'b0, '0);
         got0_q.delete();
         got1_q.delete();
         for (int k = 0; k < NUMLAYERS; k++) begin
            lv_rise[k] = 0;
            fv_rise[k] = 0;
         end
         fill_image(tbl[i]);
         build_model(tbl[i]);
         send_frame(tbl[i]);
         wait_drain(i);
         // Tail catches any extra output
         repeat (6) drive_cycle(1'b0, 1'b0, 1'b0, '0);
         compare_frame(i, tbl[i]);
      end

      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// File: pyramid_gen.f
source/pyr_pkg.sv
source/pyr_sync_track.sv
source/pyr_pair_reduce.sv
source/pyr_vert_reduce.sv
source/pyr_layer.sv
source/pyramid_gen.sv
verif/pyramid_gen_tb.sv

// File: Bender.yml
package:
  name: pyramid_gen

sources:
  # RTL in compile order
  - files:
      - source/pyr_pkg.sv
      - source/pyr_sync_track.sv
      - source/pyr_pair_reduce.sv
      - source/pyr_vert_reduce.sv
      - source/pyr_layer.sv
      - source/pyramid_gen.sv

  # Testbench
  - target: test
    files:
      - verif/pyramid_gen_tb.sv
